// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - rtl/exu_pkg.sv
  - rtl/exu_stage_buffer.sv
  - rtl/exu_alu.sv
  - rtl/exu_branch_unit.sv
  - rtl/exu_result_merge.sv
  - rtl/exu_top.sv
  - target: test
    files:
      - verification/exu_tb_clock.sv
      - verification/exu_tb.sv

// ==== project.f ====
rtl/exu_pkg.sv
rtl/exu_stage_buffer.sv
rtl/exu_alu.sv
rtl/exu_branch_unit.sv
rtl/exu_result_merge.sv
rtl/exu_top.sv
verification/exu_tb_clock.sv
verification/exu_tb.sv

// ==== rtl/exu_alu.sv ====
module exu_alu (
  input  logic [exu_pkg::XLEN-1:0]     s_src1,
  input  logic [exu_pkg::XLEN-1:0]     s_src2,
  input  logic [exu_pkg::ALU_OP_W-1:0] s_alu_op,
  output logic [exu_pkg::XLEN-1:0]     alu_result,
  output logic                         zero
);

  logic [exu_pkg::XLEN-1:0] sum;
  logic [exu_pkg::XLEN-1:0] diff;
  logic [4:0]               shamt;
  logic                     lt_signed;
  logic                     lt_unsigned;
  logic                     is_arith;

  assign sum   = s_src1 + s_src2;
  assign diff  = s_src1 - s_src2;
  assign shamt = s_src2[4:0];

  assign lt_signed   = $signed(s_src1) < $signed(s_src2);
  assign lt_unsigned = s_src1 < s_src2;

  always_comb begin
    case (s_alu_op)
      exu_pkg::ALU_IMM: begin
        // Decoder routes the immediate through src2
        alu_result = s_src2;
      end
      exu_pkg::ALU_ADD: begin
        alu_result = sum;
      end
      exu_pkg::ALU_SUB: begin
        alu_result = diff;
      end
      exu_pkg::ALU_AND: begin
        alu_result = s_src1 & s_src2;
      end
      exu_pkg::ALU_XOR: begin
        alu_result = s_src1 ^ s_src2;
      end
      exu_pkg::ALU_OR: begin
        alu_result = s_src1 | s_src2;
      end
      exu_pkg::ALU_SL: begin
        alu_result = s_src1 << shamt;
      end
      exu_pkg::ALU_SR: begin
        alu_result = s_src1 >> shamt;
      end
      exu_pkg::ALU_SSR: begin
        alu_result = $unsigned($signed(s_src1) >>> shamt);
      end
      exu_pkg::ALU_SLES: begin
        alu_result = {{(exu_pkg::XLEN-1){1'b0}}, lt_signed};
      end
      exu_pkg::ALU_ULES: begin
        alu_result = {{(exu_pkg::XLEN-1){1'b0}}, lt_unsigned};
      end
      exu_pkg::ALU_SRC: begin
        alu_result = s_src1;
      end
      default: begin
        alu_result = '0;
      end
    endcase
  end

  // Zero flag only meaningful for add and sub
  assign is_arith = (s_alu_op == exu_pkg::ALU_ADD) || (s_alu_op == exu_pkg::ALU_SUB);
  assign zero     = is_arith && (alu_result == '0);

endmodule

// ==== rtl/exu_branch_unit.sv ====
module exu_branch_unit (
  input  logic [exu_pkg::XLEN-1:0]    s_src1,
  input  logic [exu_pkg::XLEN-1:0]    s_rsb,
  input  logic [exu_pkg::B_OP_W-1:0]  s_b_op,
  input  logic [exu_pkg::PC_OP_W-1:0] s_pc_op,
  input  logic [exu_pkg::XLEN-1:0]    s_imm,
  input  logic [exu_pkg::XLEN-1:0]    s_pc,
  input  logic [exu_pkg::XLEN-1:0]    s_pc_next,
  output logic [exu_pkg::XLEN-1:0]    br_target
);

  logic                     eq;
  logic                     lt;
  logic                     ltu;
  logic                     taken;
  logic [exu_pkg::XLEN-1:0] pc_rel;
  logic [exu_pkg::XLEN-1:0] reg_rel;

  assign eq  = s_src1 == s_rsb;
  assign lt  = $signed(s_src1) < $signed(s_rsb);
  assign ltu = s_src1 < s_rsb;

  always_comb begin
    case (s_b_op)
      exu_pkg::B_EQ:  taken = eq;
      exu_pkg::B_NE:  taken = !eq;
      exu_pkg::B_LT:  taken = lt;
      exu_pkg::B_GE:  taken = !lt;
      exu_pkg::B_LTU: taken = ltu;
      exu_pkg::B_GEU: taken = !ltu;
      default:        taken = 1'b0;
    endcase
  end

  assign pc_rel  = s_pc + s_imm;
  // jalr drops the low bit of the sum
  assign reg_rel = (s_src1 + s_imm) & ~{{(exu_pkg::XLEN-1){1'b0}}, 1'b1};

  always_comb begin
    case (s_pc_op)
      exu_pkg::PC_JAL:  br_target = pc_rel;
      exu_pkg::PC_JALR: br_target = reg_rel;
      exu_pkg::PC_BR:   br_target = taken ? pc_rel : s_pc_next;
      default:          br_target = s_pc_next;
    endcase
  end

endmodule

// ==== rtl/exu_pkg.sv ====
package exu_pkg;

  localparam int XLEN = 32;

  // ALU operation codes
  localparam int ALU_OP_W = 5;

  localparam logic [ALU_OP_W-1:0] ALU_IMM  = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_ADD  = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SUB  = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_AND  = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_XOR  = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_OR   = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SL   = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SR   = 5'd7;
  // 8 held by divide, not implemented
  localparam logic [ALU_OP_W-1:0] ALU_SSR  = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_SLES = 5'd10;
  localparam logic [ALU_OP_W-1:0] ALU_ULES = 5'd11;
  // 12 to 15 held by mul/div/rem variants
  localparam logic [ALU_OP_W-1:0] ALU_SRC  = 5'd16;

  // Branch conditions
  localparam int B_OP_W = 3;

  localparam logic [B_OP_W-1:0] B_NONE = 3'd0;
  localparam logic [B_OP_W-1:0] B_EQ   = 3'd1;
  localparam logic [B_OP_W-1:0] B_NE   = 3'd2;
  localparam logic [B_OP_W-1:0] B_LT   = 3'd3;
  localparam logic [B_OP_W-1:0] B_GE   = 3'd4;
  localparam logic [B_OP_W-1:0] B_LTU  = 3'd5;
  localparam logic [B_OP_W-1:0] B_GEU  = 3'd6;

  // Next pc selection
  localparam int PC_OP_W = 2;

  localparam logic [PC_OP_W-1:0] PC_SEQ  = 2'd0;
  localparam logic [PC_OP_W-1:0] PC_JAL  = 2'd1;
  localparam logic [PC_OP_W-1:0] PC_JALR = 2'd2;
  localparam logic [PC_OP_W-1:0] PC_BR   = 2'd3;

  // Writeback data selection
  localparam int WD_OP_W = 2;

  localparam logic [WD_OP_W-1:0] WD_ALU  = 2'd0;
  localparam logic [WD_OP_W-1:0] WD_LINK = 2'd1;
  localparam logic [WD_OP_W-1:0] WD_IMM  = 2'd2;
  localparam logic [WD_OP_W-1:0] WD_NONE = 2'd3;

endpackage

// ==== rtl/exu_result_merge.sv ====
module exu_result_merge (
  input  logic [exu_pkg::XLEN-1:0]    alu_result,
  input  logic [exu_pkg::XLEN-1:0]    br_target,
  input  logic [exu_pkg::WD_OP_W-1:0] s_wd_op,
  input  logic [exu_pkg::XLEN-1:0]    s_imm,
  input  logic [exu_pkg::XLEN-1:0]    s_pc_next,
  input  logic                        s_reg_write_en,
  input  logic [4:0]                  s_rd,
  input  logic                        out_valid,
  output logic [exu_pkg::XLEN-1:0]    wb_data,
  output logic                        wb_en,
  output logic [4:0]                  wb_rd,
  output logic                        redirect,
  output logic [exu_pkg::XLEN-1:0]    target_pc
);

  logic wd_active;
  logic rd_nonzero;

  always_comb begin
    case (s_wd_op)
      exu_pkg::WD_ALU:  wb_data = alu_result;
      exu_pkg::WD_LINK: wb_data = s_pc_next;
      exu_pkg::WD_IMM:  wb_data = s_imm;
      default:          wb_data = '0;
    endcase
  end

  assign wd_active  = s_wd_op != exu_pkg::WD_NONE;
  // x0 writes are dropped here
  assign rd_nonzero = s_rd != 5'd0;

  assign wb_en = out_valid && s_reg_write_en && wd_active && rd_nonzero;
  assign wb_rd = s_rd;

  // Fetch only needs to hear about a non-sequential pc
  assign redirect  = out_valid && (br_target != s_pc_next);
  assign target_pc = br_target;

endmodule

// ==== rtl/exu_stage_buffer.sv ====
module exu_stage_buffer (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  output logic                           in_ready,
  input  logic [exu_pkg::XLEN-1:0]       src1,
  input  logic [exu_pkg::XLEN-1:0]       src2,
  input  logic [exu_pkg::XLEN-1:0]       rsb,
  input  logic [exu_pkg::ALU_OP_W-1:0]   alu_op,
  input  logic [exu_pkg::XLEN-1:0]       imm,
  input  logic [exu_pkg::PC_OP_W-1:0]    pc_op,
  input  logic [exu_pkg::WD_OP_W-1:0]    wd_op,
  input  logic [exu_pkg::B_OP_W-1:0]     b_op,
  input  logic                           reg_write_en,
  input  logic [exu_pkg::XLEN-1:0]       pc,
  input  logic [exu_pkg::XLEN-1:0]       pc_next,
  input  logic [4:0]                     rd,
  input  logic                           out_ready,
  output logic                           out_valid,
  output logic [exu_pkg::XLEN-1:0]       s_src1,
  output logic [exu_pkg::XLEN-1:0]       s_src2,
  output logic [exu_pkg::XLEN-1:0]       s_rsb,
  output logic [exu_pkg::ALU_OP_W-1:0]   s_alu_op,
  output logic [exu_pkg::XLEN-1:0]       s_imm,
  output logic [exu_pkg::PC_OP_W-1:0]    s_pc_op,
  output logic [exu_pkg::WD_OP_W-1:0]    s_wd_op,
  output logic [exu_pkg::B_OP_W-1:0]     s_b_op,
  output logic                           s_reg_write_en,
  output logic [exu_pkg::XLEN-1:0]       s_pc,
  output logic [exu_pkg::XLEN-1:0]       s_pc_next,
  output logic [4:0]                     s_rd
);

  // Skid entry
  logic                         sk_full;
  logic [exu_pkg::XLEN-1:0]     sk_src1;
  logic [exu_pkg::XLEN-1:0]     sk_src2;
  logic [exu_pkg::XLEN-1:0]     sk_rsb;
  logic [exu_pkg::ALU_OP_W-1:0] sk_alu_op;
  logic [exu_pkg::XLEN-1:0]     sk_imm;
  logic [exu_pkg::PC_OP_W-1:0]  sk_pc_op;
  logic [exu_pkg::WD_OP_W-1:0]  sk_wd_op;
  logic [exu_pkg::B_OP_W-1:0]   sk_b_op;
  logic                         sk_reg_write_en;
  logic [exu_pkg::XLEN-1:0]     sk_pc;
  logic [exu_pkg::XLEN-1:0]     sk_pc_next;
  logic [4:0]                   sk_rd;

  logic in_fire;
  logic stage_free;

  assign in_ready   = !sk_full;
  assign in_fire    = in_valid && in_ready;
  // Stage can take a new entry when empty or handing off this cycle
  assign stage_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      sk_full   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (stage_free) begin
        out_valid <= sk_full || in_fire;
        sk_full   <= 1'b0;
      end else if (in_fire) begin
        sk_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire && !stage_free) begin
      sk_src1         <= src1;
      sk_src2         <= src2;
      sk_rsb          <= rsb;
      sk_alu_op       <= alu_op;
      sk_imm          <= imm;
      sk_pc_op        <= pc_op;
      sk_wd_op        <= wd_op;
      sk_b_op         <= b_op;
      sk_reg_write_en <= reg_write_en;
      sk_pc           <= pc;
      sk_pc_next      <= pc_next;
      sk_rd           <= rd;
    end
  end

  // Older skid entry goes first
  always_ff @(posedge clk) begin
    if (stage_free && (sk_full || in_fire)) begin
      s_src1         <= sk_full ? sk_src1 : src1;
      s_src2         <= sk_full ? sk_src2 : src2;
      s_rsb          <= sk_full ? sk_rsb : rsb;
      s_alu_op       <= sk_full ? sk_alu_op : alu_op;
      s_imm          <= sk_full ? sk_imm : imm;
      s_pc_op        <= sk_full ? sk_pc_op : pc_op;
      s_wd_op        <= sk_full ? sk_wd_op : wd_op;
      s_b_op         <= sk_full ? sk_b_op : b_op;
      s_reg_write_en <= sk_full ? sk_reg_write_en : reg_write_en;
      s_pc           <= sk_full ? sk_pc : pc;
      s_pc_next      <= sk_full ? sk_pc_next : pc_next;
      s_rd           <= sk_full ? sk_rd : rd;
    end
  end

endmodule

// ==== rtl/exu_top.sv ====
module exu_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  logic [exu_pkg::XLEN-1:0]     src1,
  input  logic [exu_pkg::XLEN-1:0]     src2,
  input  logic [exu_pkg::XLEN-1:0]     rsb,
  input  logic [exu_pkg::ALU_OP_W-1:0] alu_op,
  input  logic [exu_pkg::XLEN-1:0]     imm,
  input  logic [exu_pkg::PC_OP_W-1:0]  pc_op,
  input  logic [exu_pkg::WD_OP_W-1:0]  wd_op,
  input  logic [exu_pkg::B_OP_W-1:0]   b_op,
  input  logic                         reg_write_en,
  input  logic [exu_pkg::XLEN-1:0]     pc,
  input  logic [exu_pkg::XLEN-1:0]     pc_next,
  input  logic [4:0]                   rd,
  input  logic                         out_ready,
  output logic                         out_valid,
  output logic [exu_pkg::XLEN-1:0]     wb_data,
  output logic                         wb_en,
  output logic [4:0]                   wb_rd,
  output logic                         zero,
  output logic                         redirect,
  output logic [exu_pkg::XLEN-1:0]     target_pc
);

  logic [exu_pkg::XLEN-1:0]     s_src1;
  logic [exu_pkg::XLEN-1:0]     s_src2;
  logic [exu_pkg::XLEN-1:0]     s_rsb;
  logic [exu_pkg::ALU_OP_W-1:0] s_alu_op;
  logic [exu_pkg::XLEN-1:0]     s_imm;
  logic [exu_pkg::PC_OP_W-1:0]  s_pc_op;
  logic [exu_pkg::WD_OP_W-1:0]  s_wd_op;
  logic [exu_pkg::B_OP_W-1:0]   s_b_op;
  logic                         s_reg_write_en;
  logic [exu_pkg::XLEN-1:0]     s_pc;
  logic [exu_pkg::XLEN-1:0]     s_pc_next;
  logic [4:0]                   s_rd;
  logic [exu_pkg::XLEN-1:0]     alu_result;
  logic [exu_pkg::XLEN-1:0]     br_target;

  exu_stage_buffer i_exu_stage_buffer (
    .clk, .rst, .in_valid, .in_ready,
    .src1, .src2, .rsb, .alu_op, .imm, .pc_op, .wd_op, .b_op,
    .reg_write_en, .pc, .pc_next, .rd,
    .out_ready, .out_valid,
    .s_src1, .s_src2, .s_rsb, .s_alu_op, .s_imm, .s_pc_op, .s_wd_op, .s_b_op,
    .s_reg_write_en, .s_pc, .s_pc_next, .s_rd
  );

  exu_alu i_exu_alu (
    .s_src1, .s_src2, .s_alu_op, .alu_result, .zero
  );

  exu_branch_unit i_exu_branch_unit (
    .s_src1, .s_rsb, .s_b_op, .s_pc_op, .s_imm, .s_pc, .s_pc_next, .br_target
  );

  exu_result_merge i_exu_result_merge (
    .alu_result, .br_target, .s_wd_op, .s_imm, .s_pc_next, .s_reg_write_en,
    .s_rd, .out_valid, .wb_data, .wb_en, .wb_rd, .redirect, .target_pc
  );

endmodule

// ==== verification/exu_tb.sv ====
module exu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  // Words per vector line
  localparam int NF      = 19;
  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 200;

  localparam int READY_RANDOM = 0;
  localparam int READY_HIGH   = 1;
  localparam int READY_LOW    = 2;

  logic                         clk;
  logic                         rst;
  logic                         in_valid;
  logic                         in_ready;
  logic [exu_pkg::XLEN-1:0]     src1;
  logic [exu_pkg::XLEN-1:0]     src2;
  logic [exu_pkg::XLEN-1:0]     rsb;
  logic [exu_pkg::ALU_OP_W-1:0] alu_op;
  logic [exu_pkg::XLEN-1:0]     imm;
  logic [exu_pkg::PC_OP_W-1:0]  pc_op;
  logic [exu_pkg::WD_OP_W-1:0]  wd_op;
  logic [exu_pkg::B_OP_W-1:0]   b_op;
  logic                         reg_write_en;
  logic [exu_pkg::XLEN-1:0]     pc;
  logic [exu_pkg::XLEN-1:0]     pc_next;
  logic [4:0]                   rd;
  logic                         out_ready;
  logic                         out_valid;
  logic [exu_pkg::XLEN-1:0]     wb_data;
  logic                         wb_en;
  logic [4:0]                   wb_rd;
  logic                         zero;
  logic                         redirect;
  logic [exu_pkg::XLEN-1:0]     target_pc;

  logic [31:0] vec_mem [0:NF*MAX_VEC-1];
  int          num_vec;
  // Vector index and acceptance cycle of each instruction in flight
  int          pending[$];
  int          pending_cycle[$];
  int          cur_idx;
  int          cycle;
  int          checks;
  int          errors;
  int          tests;
  int          ready_mode;
  bit          check_latency;
  bit          abort;
  logic [31:0] rng;

  exu_tb_clock i_exu_tb_clock (.clk);

  exu_top i_exu_top (
    .clk, .rst, .in_valid, .in_ready,
    .src1, .src2, .rsb, .alu_op, .imm, .pc_op, .wd_op, .b_op,
    .reg_write_en, .pc, .pc_next, .rd,
    .out_ready, .out_valid,
    .wb_data, .wb_en, .wb_rd, .zero, .redirect, .target_pc
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    abort = 1'b1;
    $display("Timeout at time %0t: %s", $time, what);
  endtask

  task automatic report_test(input int num, input string name, input int checks0,
                             input int errors0);
    tests++;
    $display("Test %0d %s: %0d checks, %0d errors", num, name, checks - checks0,
             errors - errors0);
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base         = idx * NF;
    cur_idx      = idx;
    in_valid     = 1'b1;
    src1         = vec_mem[base+1];
    src2         = vec_mem[base+2];
    rsb          = vec_mem[base+3];
    alu_op       = vec_mem[base+4][exu_pkg::ALU_OP_W-1:0];
    imm          = vec_mem[base+5];
    pc_op        = vec_mem[base+6][exu_pkg::PC_OP_W-1:0];
    wd_op        = vec_mem[base+7][exu_pkg::WD_OP_W-1:0];
    b_op         = vec_mem[base+8][exu_pkg::B_OP_W-1:0];
    reg_write_en = vec_mem[base+9][0];
    pc           = vec_mem[base+10];
    pc_next      = vec_mem[base+11];
    rd           = vec_mem[base+12][4:0];
  endtask

  task automatic check_output();
    int    idx;
    int    base;
    int    accepted_at;
    string tag;
    checks++;
    assert (pending.size() != 0) else begin
      errors++;
      $display("Output transfer at time %0t with no instruction pending", $time);
    end
    if (pending.size() != 0) begin
      idx         = pending.pop_front();
      accepted_at = pending_cycle.pop_front();
      base        = idx * NF;
      tag         = $sformatf("vector %0d", idx);
      check_value({tag, " wb_data"}, wb_data, vec_mem[base+13]);
      check_value({tag, " wb_en"}, wb_en, vec_mem[base+14]);
      check_value({tag, " wb_rd"}, wb_rd, vec_mem[base+15]);
      check_value({tag, " zero"}, zero, vec_mem[base+16]);
      check_value({tag, " redirect"}, redirect, vec_mem[base+17]);
      check_value({tag, " target_pc"}, target_pc, vec_mem[base+18]);
      if (check_latency) begin
        check_value({tag, " latency"}, cycle - accepted_at, 1);
      end
    end
  endtask

  // Advances one cycle between falling edges
  task automatic step(output bit accepted);
    if (ready_mode == READY_RANDOM) begin
      rng       = xorshift(rng);
      out_ready = rng[1:0] != 2'b00;
    end else begin
      out_ready = ready_mode == READY_HIGH;
    end
    if (out_valid && out_ready) begin
      check_output();
    end
    if (!out_valid) begin
      check_value("wb_en without out_valid", wb_en, 1'b0);
      check_value("redirect without out_valid", redirect, 1'b0);
    end
    accepted = in_valid && in_ready;
    if (accepted) begin
      pending.push_back(cur_idx);
      pending_cycle.push_back(cycle);
    end
    @(negedge clk);
    cycle++;
  endtask

  task automatic send_vector(input int idx);
    bit accepted;
    int waited;
    drive_vector(idx);
    accepted = 1'b0;
    waited   = 0;
    while (!accepted && !abort) begin
      if (waited == TIMEOUT) begin
        report_timeout($sformatf("vector %0d was not accepted in %0d cycles", idx, TIMEOUT));
      end else begin
        step(accepted);
        waited++;
      end
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    bit accepted;
    int waited;
    in_valid = 1'b0;
    waited   = 0;
    while (!abort && (pending.size() != 0 || out_valid)) begin
      if (waited == TIMEOUT) begin
        report_timeout($sformatf("%0d results never came out", pending.size()));
      end else begin
        step(accepted);
        waited++;
      end
    end
  endtask

  task automatic collect(input int group, ref int list[$]);
    int i;
    list.delete();
    for (i = 0; i < num_vec; i++) begin
      if (vec_mem[i*NF] == group) begin
        list.push_back(i);
      end
    end
  endtask

  task automatic run_group(input int group, input string name);
    int list[$];
    int checks0;
    int errors0;
    checks0 = checks;
    errors0 = errors;
    collect(group, list);
    ready_mode = READY_RANDOM;
    foreach (list[i]) begin
      if (!abort) begin
        send_vector(list[i]);
      end
    end
    drain();
    report_test(group, name, checks0, errors0);
  endtask

  task automatic run_backpressure();
    int list[$];
    int checks0;
    int errors0;
    int taken;
    int offered;
    bit accepted;
    checks0 = checks;
    errors0 = errors;
    collect(5, list);
    taken = 0;
    // Stage and skid fill up before the input stalls
    ready_mode = READY_LOW;
    for (offered = 0; offered < 6 && !abort; offered++) begin
      if (taken < list.size()) begin
        drive_vector(list[taken]);
      end else begin
        in_valid = 1'b0;
      end
      step(accepted);
      if (accepted) begin
        taken++;
      end
    end
    check_value("instructions accepted while stalled", taken, 2);
    check_value("in_ready while stalled", in_ready, 1'b0);
    check_value("out_valid while stalled", out_valid, 1'b1);
    ready_mode = READY_RANDOM;
    while (!abort && taken < list.size()) begin
      send_vector(list[taken]);
      taken++;
    end
    drain();
    report_test(5, "back-pressure", checks0, errors0);
  endtask

  task automatic run_reset_stream();
    int list[$];
    int checks0;
    int errors0;
    checks0 = checks;
    errors0 = errors;
    collect(6, list);
    // Reset arrives with the stage and skid both full
    ready_mode = READY_LOW;
    out_ready  = 1'b0;
    drive_vector(list[0]);
    repeat (2) @(negedge clk);
    in_valid = 1'b0;
    check_value("in_ready before reset", in_ready, 1'b0);
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_value("out_valid after reset", out_valid, 1'b0);
    check_value("in_ready after reset", in_ready, 1'b1);
    ready_mode    = READY_HIGH;
    check_latency = 1'b1;
    foreach (list[i]) begin
      if (!abort) begin
        send_vector(list[i]);
      end
    end
    drain();
    check_latency = 1'b0;
    report_test(6, "reset and streaming", checks0, errors0);
  endtask

  initial begin
    rst           = 1'b1;
    in_valid      = 1'b0;
    src1          = '0;
    src2          = '0;
    rsb           = '0;
    alu_op        = '0;
    imm           = '0;
    pc_op         = '0;
    wd_op         = '0;
    b_op          = '0;
    reg_write_en  = 1'b0;
    pc            = '0;
    pc_next       = '0;
    rd            = '0;
    out_ready     = 1'b0;
    rng           = 32'h1373_1a1a;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    cycle         = 0;
    cur_idx       = 0;
    abort         = 1'b0;
    check_latency = 1'b0;
    ready_mode    = READY_RANDOM;
    $readmemh("verification/exu_vectors.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*NF])) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      errors++;
      abort = 1'b1;
      $display("No vectors could be read from verification/exu_vectors.txt");
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    run_group(1, "ALU operations");
    run_group(2, "branches");
    run_group(3, "jumps");
    run_group(4, "writeback gating");
    run_backpressure();
    run_reset_stream();
    $display("Total: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== verification/exu_tb_clock.sv ====
module exu_tb_clock (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

// ==== verification/exu_vectors.txt ====
// test src1 src2 rsb alu_op imm pc_op wd_op b_op reg_write_en pc pc_next rd, all hex
// then expected wb_data wb_en wb_rd zero redirect target_pc
1 deadbeef 800 0 0 0 0 0 0 1 100 104 1 800 1 1 0 0 104
1 5 0 0 0 0 0 0 0 1 100 104 18 0 1 18 0 0 104
1 5 3 0 1 0 0 0 0 1 100 104 2 8 1 2 0 0 104
1 ffffffff 1 0 1 0 0 0 0 1 100 104 3 0 1 3 1 0 104
1 7 7 0 2 0 0 0 0 1 100 104 4 0 1 4 1 0 104
1 3 5 0 2 0 0 0 0 1 100 104 5 fffffffe 1 5 0 0 104
1 f0f0f0f0 0ff00ff0 0 3 0 0 0 0 1 100 104 6 00f000f0 1 6 0 0 104
1 f0f0f0f0 0ff00ff0 0 4 0 0 0 0 1 100 104 7 ff00ff00 1 7 0 0 104
1 f0f0f0f0 0ff00ff0 0 5 0 0 0 0 1 100 104 8 fff0fff0 1 8 0 0 104
1 12345678 0 0 6 0 0 0 0 1 100 104 9 12345678 1 9 0 0 104
1 3 1f 0 6 0 0 0 0 1 100 104 a 80000000 1 a 0 0 104
1 3 21 0 6 0 0 0 0 1 100 104 b 6 1 b 0 0 104
1 80000000 1f 0 7 0 0 0 0 1 100 104 c 1 1 c 0 0 104
1 f0000000 4 0 7 0 0 0 0 1 100 104 d 0f000000 1 d 0 0 104
1 f0000000 4 0 9 0 0 0 0 1 100 104 e ff000000 1 e 0 0 104
1 80000000 1f 0 9 0 0 0 0 1 100 104 f ffffffff 1 f 0 0 104
1 7ffffff0 4 0 9 0 0 0 0 1 100 104 10 07ffffff 1 10 0 0 104
1 80000000 7fffffff 0 a 0 0 0 0 1 100 104 11 1 1 11 0 0 104
1 80000000 7fffffff 0 b 0 0 0 0 1 100 104 12 0 1 12 0 0 104
1 7fffffff 80000000 0 a 0 0 0 0 1 100 104 13 0 1 13 0 0 104
1 1 ffffffff 0 b 0 0 0 0 1 100 104 14 1 1 14 0 0 104
1 cafef00d 1234 0 10 0 0 0 0 1 100 104 15 cafef00d 1 15 0 0 104
1 5 3 0 8 0 0 0 0 1 100 104 16 0 1 16 0 0 104
1 5 3 0 1f 0 0 0 0 1 100 104 17 0 1 17 0 0 104
2 5 0 5 0 40 3 3 1 0 200 204 0 0 0 0 0 1 240
2 5 0 6 0 40 3 3 1 0 200 204 0 0 0 0 0 0 204
2 5 0 6 0 fffffff0 3 3 2 0 200 204 0 0 0 0 0 1 1f0
2 5 0 5 0 fffffff0 3 3 2 0 200 204 0 0 0 0 0 0 204
2 ffffffff 0 1 0 40 3 3 3 0 200 204 0 0 0 0 0 1 240
2 1 0 ffffffff 0 40 3 3 3 0 200 204 0 0 0 0 0 0 204
2 1 0 ffffffff 0 40 3 3 4 0 200 204 0 0 0 0 0 1 240
2 7 0 7 0 40 3 3 4 0 200 204 0 0 0 0 0 1 240
2 ffffffff 0 1 0 40 3 3 4 0 200 204 0 0 0 0 0 0 204
2 1 0 ffffffff 0 40 3 3 5 0 200 204 0 0 0 0 0 1 240
2 ffffffff 0 1 0 40 3 3 5 0 200 204 0 0 0 0 0 0 204
2 ffffffff 0 1 0 40 3 3 6 0 200 204 0 0 0 0 0 1 240
2 1 0 ffffffff 0 40 3 3 6 0 200 204 0 0 0 0 0 0 204
2 5 0 5 0 40 3 3 0 0 200 204 0 0 0 0 0 0 204
3 0 0 0 0 100 1 1 0 1 300 304 1 304 1 1 0 1 400
3 0 0 0 0 fffffe00 1 1 0 1 300 304 2 304 1 2 0 1 100
3 1001 0 0 0 10 2 1 0 1 300 304 5 304 1 5 0 1 1010
3 2000 0 0 0 7 2 1 0 1 300 304 6 304 1 6 0 1 2006
3 300 0 0 0 4 2 1 0 1 300 304 7 304 1 7 0 0 304
4 1 2 0 1 12345000 0 2 0 1 100 104 7 12345000 1 7 0 0 104
4 1 2 0 1 0 0 3 0 1 100 104 8 0 0 8 0 0 104
4 4 5 0 1 0 0 0 0 1 100 104 0 9 0 0 0 0 104
4 6 6 0 2 0 0 0 0 0 100 104 9 0 0 9 1 0 104
5 10 1 0 1 0 0 0 0 1 500 504 1 11 1 1 0 0 504
5 20 2 0 1 0 0 0 0 1 504 508 2 22 1 2 0 0 508
5 30 3 0 1 0 0 0 0 1 508 50c 3 33 1 3 0 0 50c
5 40 4 0 1 0 0 0 0 1 50c 510 4 44 1 4 0 0 510
6 100 200 0 1 0 0 0 0 1 600 604 1a 300 1 1a 0 0 604
6 1000 1 0 2 0 0 0 0 1 604 608 1b fff 1 1b 0 0 608
6 a0 b 0 5 0 0 0 0 1 608 60c 1c ab 1 1c 0 0 60c
6 ff f 0 4 0 0 0 0 1 60c 610 1d f0 1 1d 0 0 610
6 5 0 5 0 20 3 3 1 0 610 614 0 0 0 0 0 1 630
